// File: logic/alloc_if.sv
// allocation signals between route compute, the per-output arbiters
// and the crossbar
//   req   row o holds the inputs requesting output o
//   gnt   one-hot row per output naming the winning input
//   sel   winning input code per output
//   busy  grant made on that output this cycle

`timescale 1ns/10ps

`include "noc_config.svh"

interface alloc_if;

  logic [`NOC_PORTS-1:0] req [`NOC_PORTS];
  logic [`NOC_PORTS-1:0] gnt [`NOC_PORTS];
  noc_pkg::port_e        sel [`NOC_PORTS];
  logic [`NOC_PORTS-1:0] busy;

  modport rc (
    output req
  );

  // each arbiter drives only its own row and entries
  modport arb (
    input  req,
    output gnt,
    output sel,
    output busy
  );

  modport xbar (
    input gnt,
    input sel,
    input busy
  );

endinterface

// File: logic/crossbar.sv
// registered flit crossbar
// each output captures the flit of its winning input, out_valid_o
// follows one cycle after the grant
// input ready is the OR of that input's grants over all outputs

`timescale 1ns/10ps

`include "noc_config.svh"

module crossbar (
  input  logic                  clk,
  input  logic                  rst_i,
  input  noc_pkg::flit_t        in_flit_i [`NOC_PORTS],
  alloc_if.xbar                 alloc,
  output logic [`NOC_PORTS-1:0] in_ready_o,
  output noc_pkg::flit_t        out_flit_o [`NOC_PORTS],
  output logic [`NOC_PORTS-1:0] out_valid_o
);

  noc_pkg::flit_t        out_flit_q [`NOC_PORTS];
  logic [`NOC_PORTS-1:0] out_valid_q;
  logic [`NOC_PORTS-1:0] ready_n;

  // an input is taken when any output grants it
  always_comb begin
    ready_n = '0;
    for (int o = 0; o < `NOC_PORTS; o++) begin
      ready_n = ready_n | alloc.gnt[o];
    end
  end

  assign in_ready_o = ready_n;

  // data path, loaded only on a grant
  always_ff @(posedge clk) begin
    for (int o = 0; o < `NOC_PORTS; o++) begin
      if (alloc.busy[o]) begin
        out_flit_q[o] <= in_flit_i[alloc.sel[o]];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      out_valid_q <= '0;
    end else begin
      // one cycle per transfer
      out_valid_q <= alloc.busy;
    end
  end

  assign out_flit_o  = out_flit_q;
  assign out_valid_o = out_valid_q;

endmodule

// File: logic/noc_config.svh
// router build constants
//   NOC_PORTS     number of router ports (N, S, W, E, L)
//   NOC_COORD_W   width of one mesh coordinate
//   NOC_DATA_W    flit payload width

`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// five ports, mesh router with local injection
`define NOC_PORTS 5

// up to an 8x8 mesh
`define NOC_COORD_W 3

// payload carried by each single-flit packet
`define NOC_DATA_W 16

`endif

// File: logic/noc_pkg.sv
// router types
//   port_e   3-bit port code, also used as the crossbar select
//   flit_t   single-flit packet with destination and payload

`include "noc_config.svh"

package noc_pkg;

  // same numbering as the input and output port indices
  typedef enum logic [2:0] {
    PORT_N = 3'd0,
    PORT_S = 3'd1,
    PORT_W = 3'd2,
    PORT_E = 3'd3,
    PORT_L = 3'd4
  } port_e;

  // destination first, payload in the low bits
  typedef struct packed {
    logic [`NOC_COORD_W-1:0] dest_x;
    logic [`NOC_COORD_W-1:0] dest_y;
    logic [`NOC_DATA_W-1:0]  payload;
  } flit_t;

endpackage

// File: logic/noc_switch_top.sv
// switch allocation and traversal stage of one mesh router
//   route_compute   XY route per input
//   rr_arbiter      one per output, generate loop
//   crossbar        registered flit transfer and input ready

`timescale 1ns/10ps

`include "noc_config.svh"

module noc_switch_top #(
  parameter logic [`NOC_COORD_W-1:0] X_POS = '0,
  parameter logic [`NOC_COORD_W-1:0] Y_POS = '0
) (
  input  logic                  clk,
  input  logic                  rst_i,

  // input side, valid/ready per port
  input  logic [`NOC_PORTS-1:0] in_valid_i,
  input  noc_pkg::flit_t        in_flit_i [`NOC_PORTS],
  output logic [`NOC_PORTS-1:0] in_ready_o,

  // output side, credit is a level from downstream
  input  logic [`NOC_PORTS-1:0] credit_i,
  output logic [`NOC_PORTS-1:0] out_valid_o,
  output noc_pkg::flit_t        out_flit_o [`NOC_PORTS]
);

  alloc_if alloc ();

  route_compute #(
    .X_POS (X_POS),
    .Y_POS (Y_POS)
  ) route_compute_inst (
    .in_valid_i (in_valid_i),
    .in_flit_i  (in_flit_i),
    .alloc      (alloc.rc)
  );

  // one arbiter per output port
  generate
    for (genvar o = 0; o < `NOC_PORTS; o++) begin : gen_arb
      rr_arbiter #(
        .OUT_PORT (o)
      ) rr_arbiter_inst (
        .clk      (clk),
        .rst_i    (rst_i),
        .credit_i (credit_i[o]),
        .alloc    (alloc.arb)
      );
    end
  endgenerate

  crossbar crossbar_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_flit_i   (in_flit_i),
    .alloc       (alloc.xbar),
    .in_ready_o  (in_ready_o),
    .out_flit_o  (out_flit_o),
    .out_valid_o (out_valid_o)
  );

endmodule

// File: logic/route_compute.sv
// XY route computation for all inputs of one router
// turns each valid flit's destination into a single request bit
// in the request matrix, x dimension first

`timescale 1ns/10ps

`include "noc_config.svh"

module route_compute #(
  parameter logic [`NOC_COORD_W-1:0] X_POS = '0,
  parameter logic [`NOC_COORD_W-1:0] Y_POS = '0
) (
  input  logic [`NOC_PORTS-1:0] in_valid_i,
  input  noc_pkg::flit_t        in_flit_i [`NOC_PORTS],
  alloc_if.rc                   alloc
);

  noc_pkg::port_e        dir [`NOC_PORTS];
  logic [`NOC_PORTS-1:0] req_n [`NOC_PORTS];

  // output port chosen for one flit
  function automatic noc_pkg::port_e xy_route(input noc_pkg::flit_t flit);
    noc_pkg::port_e route;
    if (flit.dest_x > X_POS) begin
      route = noc_pkg::PORT_E;
    end else if (flit.dest_x < X_POS) begin
      route = noc_pkg::PORT_W;
    end else if (flit.dest_y > Y_POS) begin
      route = noc_pkg::PORT_N;
    end else if (flit.dest_y < Y_POS) begin
      route = noc_pkg::PORT_S;
    end else begin
      // arrived, eject to local
      route = noc_pkg::PORT_L;
    end
    return route;
  endfunction

  always_comb begin
    for (int i = 0; i < `NOC_PORTS; i++) begin
      dir[i] = xy_route(in_flit_i[i]);
    end
  end

  // transpose: input i sets bit i of the row for its output
  always_comb begin
    for (int o = 0; o < `NOC_PORTS; o++) begin
      req_n[o] = '0;
    end
    for (int i = 0; i < `NOC_PORTS; i++) begin
      if (in_valid_i[i]) begin
        req_n[dir[i]][i] = 1'b1;
      end
    end
  end

  assign alloc.req = req_n;

endmodule

// File: logic/rr_arbiter.sv
// round-robin arbiter for one output port
// one-hot rotating pointer marks the highest-priority input,
// scan goes upward from the pointer with wraparound
// no grant while downstream credit is low, pointer then holds

`timescale 1ns/10ps

`include "noc_config.svh"

module rr_arbiter #(
  parameter int OUT_PORT = 0
) (
  input  logic clk,
  input  logic rst_i,
  input  logic credit_i,
  alloc_if.arb alloc
);

  logic [`NOC_PORTS-1:0] ptr_q;
  logic [`NOC_PORTS-1:0] req_row;
  logic [`NOC_PORTS-1:0] upper_mask;
  logic [`NOC_PORTS-1:0] req_upper;
  logic [`NOC_PORTS-1:0] pick_upper;
  logic [`NOC_PORTS-1:0] pick_any;
  logic [`NOC_PORTS-1:0] gnt_row;
  logic                  gnt_any;
  noc_pkg::port_e        sel_code;

  // lowest set bit of a request vector
  function automatic logic [`NOC_PORTS-1:0] lowest_bit(input logic [`NOC_PORTS-1:0] vec);
    return vec & (~vec + 1'b1);
  endfunction

  assign req_row = alloc.req[OUT_PORT];

  // bits at and above the pointer
  assign upper_mask = ~(ptr_q - 1'b1);
  assign req_upper  = req_row & upper_mask;

  assign pick_upper = lowest_bit(req_upper);
  assign pick_any   = lowest_bit(req_row);

  // wrap to the bottom only when nothing is left above the pointer
  always_comb begin
    if (!credit_i) begin
      gnt_row = '0;
    end else if (|req_upper) begin
      gnt_row = pick_upper;
    end else begin
      gnt_row = pick_any;
    end
  end

  assign gnt_any = |gnt_row;

  // one-hot to port code
  always_comb begin
    sel_code = noc_pkg::PORT_N;
    for (int i = 0; i < `NOC_PORTS; i++) begin
      if (gnt_row[i]) begin
        sel_code = noc_pkg::port_e'(3'(i));
      end
    end
  end

  // winner completes at this edge, so the input after it leads next
  always_ff @(posedge clk) begin
    if (rst_i) begin
      ptr_q <= `NOC_PORTS'(1);
    end else if (gnt_any) begin
      ptr_q <= {gnt_row[`NOC_PORTS-2:0], gnt_row[`NOC_PORTS-1]};
    end
  end

  assign alloc.gnt[OUT_PORT]  = gnt_row;
  assign alloc.sel[OUT_PORT]  = sel_code;
  assign alloc.busy[OUT_PORT] = gnt_any;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# compile the switch stage with its testbench and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f vlog.f \
  --top-module tb_noc_switch \
  -o sim_noc_switch

sim_out=$(./obj_dir/sim_noc_switch)
echo "$sim_out"

if grep -qx '>>> PASS' <<< "$sim_out"; then
  exit 0
fi
exit 1

// File: sim/tb_noc_vectors.svh
// directed stimulus and expected responses for the switch stage
//   one row per clock cycle, router at (2,2)
//   dest holds {x,y} per input as two octal digits, inputs listed L E W S N
//   bit vectors are also listed L E W S N, msb first
//   exp_out and exp_src describe the outputs seen in the same row
//   exp_src has one octal digit per output naming the source input

`ifndef TB_NOC_VECTORS_SVH
`define TB_NOC_VECTORS_SVH

typedef struct packed {
  logic [4:0]  valid;
  logic [29:0] dest;
  logic [4:0]  credit;
  logic [4:0]  exp_ready;
  logic [4:0]  exp_out;
  logic [14:0] exp_src;
} vec_t;

localparam int NUM_VECTORS = 20;

// valid, dest, credit, exp_ready, exp_out, exp_src
localparam vec_t VECTORS [NUM_VECTORS] = '{
  // idle after reset
  '{5'b00000, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b11111, 5'b00000, 5'b00000, 15'o00000},
  // five inputs to five distinct outputs
  '{5'b11111, {6'o22, 6'o12, 6'o32, 6'o23, 6'o21}, 5'b11111, 5'b11111, 5'b00000, 15'o00000},
  // x resolved before y
  '{5'b00011, {6'o22, 6'o22, 6'o22, 6'o11, 6'o33}, 5'b11111, 5'b00011, 5'b11111, 15'o42301},
  '{5'b11100, {6'o42, 6'o20, 6'o05, 6'o22, 6'o22}, 5'b11111, 5'b11100, 5'b01100, 15'o00100},
  // all inputs fight for local
  '{5'b11111, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b11111, 5'b00001, 5'b01110, 15'o04230},
  '{5'b11111, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b11111, 5'b00010, 5'b10000, 15'o00000},
  '{5'b11111, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b11111, 5'b00100, 5'b10000, 15'o10000},
  '{5'b11111, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b11111, 5'b01000, 5'b10000, 15'o20000},
  '{5'b11111, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b11111, 5'b10000, 5'b10000, 15'o30000},
  '{5'b11111, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b11111, 5'b00001, 5'b10000, 15'o40000},
  // no credit on local
  '{5'b11111, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b01111, 5'b00000, 5'b10000, 15'o00000},
  '{5'b11111, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b01111, 5'b00000, 5'b00000, 15'o00000},
  '{5'b11111, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b01111, 5'b00000, 5'b00000, 15'o00000},
  // credit back, held flits drain from S onward
  '{5'b11111, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b11111, 5'b00010, 5'b00000, 15'o00000},
  '{5'b11101, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b11111, 5'b00100, 5'b10000, 15'o10000},
  '{5'b11001, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b11111, 5'b01000, 5'b10000, 15'o20000},
  '{5'b10001, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b11111, 5'b10000, 5'b10000, 15'o30000},
  '{5'b00001, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b11111, 5'b00001, 5'b10000, 15'o40000},
  '{5'b00000, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b11111, 5'b00000, 5'b10000, 15'o00000},
  '{5'b00000, {6'o22, 6'o22, 6'o22, 6'o22, 6'o22}, 5'b11111, 5'b00000, 5'b00000, 15'o00000}
};

`endif

// File: sim/tb_noc_switch.sv
// testbench for the router switch allocation and traversal stage
//   directed table of routing, round robin and back-pressure cases
//   LFSR random traffic checked against a behavioral model
//   error counts and the final verdict in the closing lines

`timescale 1ns/10ps

`include "noc_config.svh"

module tb_noc_switch;

  localparam logic [`NOC_COORD_W-1:0] X_POS = `NOC_COORD_W'(2);
  localparam logic [`NOC_COORD_W-1:0] Y_POS = `NOC_COORD_W'(2);
  localparam int RANDOM_CYCLES = 400;
  localparam int DRAIN_LIMIT   = 50;

  `include "tb_noc_vectors.svh"

  logic                  clk;
  logic                  rst_i;
  logic [`NOC_PORTS-1:0] in_valid_i;
  noc_pkg::flit_t        in_flit_i [`NOC_PORTS];
  logic [`NOC_PORTS-1:0] in_ready_o;
  logic [`NOC_PORTS-1:0] credit_i;
  logic [`NOC_PORTS-1:0] out_valid_o;
  noc_pkg::flit_t        out_flit_o [`NOC_PORTS];

  // model state
  logic [`NOC_PORTS-1:0] cur_valid;
  noc_pkg::flit_t        cur_flit [`NOC_PORTS];
  logic [`NOC_PORTS-1:0] cur_credit;
  logic [`NOC_PORTS-1:0] pend_valid;
  noc_pkg::flit_t        pend_flit [`NOC_PORTS];
  int                    ptr [`NOC_PORTS];

  // inputs the DUT accepts at the coming edge
  logic [`NOC_PORTS-1:0] taken;

  logic [31:0] lfsr_state = 32'h3fd31793;
  int          checks;
  int          value_errors;
  int          timeouts;
  int          drain_cycles;

  noc_switch_top #(
    .X_POS (X_POS),
    .Y_POS (Y_POS)
  ) noc_switch_top_inst (
    .clk         (clk),
    .rst_i       (rst_i),
    .in_valid_i  (in_valid_i),
    .in_flit_i   (in_flit_i),
    .in_ready_o  (in_ready_o),
    .credit_i    (credit_i),
    .out_valid_o (out_valid_o),
    .out_flit_o  (out_flit_o)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
      value_errors++;
    end
  endtask

  // fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    logic        fb;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      bits = {bits[30:0], fb};
    end
    return bits;
  endfunction

  // payload tags the source port and destination
  function automatic noc_pkg::flit_t make_flit(input int port, input logic [5:0] dest);
    noc_pkg::flit_t f;
    f.dest_x  = dest[5:3];
    f.dest_y  = dest[2:0];
    f.payload = {4'ha, 4'(port), 2'b00, dest};
    return f;
  endfunction

  // coordinates 1..4 around the router at (2,2)
  function automatic noc_pkg::flit_t random_flit();
    noc_pkg::flit_t f;
    f.dest_x  = `NOC_COORD_W'(take_bits(2)) + `NOC_COORD_W'(1);
    f.dest_y  = `NOC_COORD_W'(take_bits(2)) + `NOC_COORD_W'(1);
    f.payload = `NOC_DATA_W'(take_bits(`NOC_DATA_W));
    return f;
  endfunction

  // dimension order routing with x first
  function automatic int xy_port(input noc_pkg::flit_t f);
    if (f.dest_x > X_POS) begin
      return int'(noc_pkg::PORT_E);
    end else if (f.dest_x < X_POS) begin
      return int'(noc_pkg::PORT_W);
    end else if (f.dest_y > Y_POS) begin
      return int'(noc_pkg::PORT_N);
    end else if (f.dest_y < Y_POS) begin
      return int'(noc_pkg::PORT_S);
    end
    return int'(noc_pkg::PORT_L);
  endfunction

  task automatic apply_reset();
    rst_i      <= 1'b1;
    in_valid_i <= '0;
    credit_i   <= '1;
    for (int i = 0; i < `NOC_PORTS; i++) begin
      in_flit_i[i] <= '0;
      cur_flit[i]  = '0;
      pend_flit[i] = '0;
      ptr[i]       = 0;
    end
    cur_valid  = '0;
    cur_credit = '1;
    taken      = '0;
    pend_valid = '0;
    repeat (5) @(posedge clk);
    rst_i <= 1'b0;
  endtask

  task automatic apply_row(input int r);
    in_valid_i <= VECTORS[r].valid;
    credit_i   <= VECTORS[r].credit;
    for (int i = 0; i < `NOC_PORTS; i++) begin
      in_flit_i[i] <= make_flit(i, VECTORS[r].dest[6*i +: 6]);
    end
  endtask

  task automatic check_row(input int r);
    vec_t           row;
    vec_t           prev;
    int             src;
    noc_pkg::flit_t exp_flit;
    row  = VECTORS[r];
    prev = VECTORS[(r > 0) ? r - 1 : 0];
    check_value("in_ready_o", 32'(in_ready_o), 32'(row.exp_ready));
    check_value("out_valid_o", 32'(out_valid_o), 32'(row.exp_out));
    for (int o = 0; o < `NOC_PORTS; o++) begin
      if (row.exp_out[o]) begin
        src      = int'(row.exp_src[3*o +: 3]);
        exp_flit = make_flit(src, prev.dest[6*src +: 6]);
        check_value($sformatf("out_flit_o[%0d]", o), 32'(out_flit_o[o]), 32'(exp_flit));
      end
    end
  endtask

  task automatic drive_inputs();
    in_valid_i <= cur_valid;
    credit_i   <= cur_credit;
    for (int i = 0; i < `NOC_PORTS; i++) begin
      in_flit_i[i] <= cur_flit[i];
    end
  endtask

  // grants from the pointer scan and last cycle's winners at the outputs
  task automatic model_step();
    int                    win [`NOC_PORTS];
    int                    idx;
    logic [`NOC_PORTS-1:0] exp_ready;
    exp_ready = '0;
    for (int o = 0; o < `NOC_PORTS; o++) begin
      win[o] = -1;
      if (cur_credit[o]) begin
        for (int k = 0; k < `NOC_PORTS && win[o] < 0; k++) begin
          idx = (ptr[o] + k) % `NOC_PORTS;
          if (cur_valid[idx] && xy_port(cur_flit[idx]) == o) begin
            win[o] = idx;
          end
        end
      end
      if (win[o] >= 0) begin
        exp_ready[win[o]] = 1'b1;
      end
    end
    check_value("in_ready_o", 32'(in_ready_o), 32'(exp_ready));
    check_value("out_valid_o", 32'(out_valid_o), 32'(pend_valid));
    for (int o = 0; o < `NOC_PORTS; o++) begin
      if (pend_valid[o]) begin
        check_value($sformatf("out_flit_o[%0d]", o), 32'(out_flit_o[o]),
                    32'(pend_flit[o]));
      end
      pend_valid[o] = (win[o] >= 0);
      if (win[o] >= 0) begin
        pend_flit[o] = cur_flit[win[o]];
        ptr[o]       = (win[o] + 1) % `NOC_PORTS;
      end
    end
  endtask

  initial begin
    checks       = 0;
    value_errors = 0;
    timeouts     = 0;
    apply_reset();

    for (int r = 0; r < NUM_VECTORS; r++) begin
      @(posedge clk);
      apply_row(r);
      @(negedge clk);
      check_row(r);
    end

    @(posedge clk);
    apply_reset();

    // sources hold a flit until it is taken
    for (int cyc = 0; cyc < RANDOM_CYCLES; cyc++) begin
      @(posedge clk);
      for (int i = 0; i < `NOC_PORTS; i++) begin
        if (!cur_valid[i] || taken[i]) begin
          cur_valid[i] = (take_bits(2) != 0);
          cur_flit[i]  = random_flit();
        end
      end
      for (int o = 0; o < `NOC_PORTS; o++) begin
        cur_credit[o] = (take_bits(2) != 0);
      end
      drive_inputs();
      @(negedge clk);
      model_step();
      taken = cur_valid & in_ready_o;
    end

    // full credit until every held flit has left
    drain_cycles = 0;
    while ((|cur_valid || |out_valid_o) && drain_cycles < DRAIN_LIMIT) begin
      @(posedge clk);
      cur_valid  = cur_valid & ~taken;
      cur_credit = '1;
      drive_inputs();
      @(negedge clk);
      model_step();
      taken = cur_valid & in_ready_o;
      drain_cycles++;
    end
    if (|cur_valid || |out_valid_o) begin
      $display("timeout: flits still held or in flight after %0d drain cycles",
               DRAIN_LIMIT);
      timeouts++;
    end

    $display("checks %0d, value errors %0d, timeouts %0d", checks, value_errors, timeouts);
    if (value_errors == 0 && timeouts == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+logic
+incdir+sim
logic/noc_pkg.sv
logic/alloc_if.sv
logic/route_compute.sv
logic/rr_arbiter.sv
logic/crossbar.sv
logic/noc_switch_top.sv
sim/tb_noc_switch.sv
